/* dv/wall_clock_asserts.sv */
`timescale 1ns/100ps

module wall_clock_asserts #(
	parameter int div_ratio = clock_pkg::TICK_DIV
) (
	input logic                               rst,
	input logic                               mclk,
	input logic [7:0]                         seg_data,
	input logic [7:0]                         seg_com,
	input logic                               am,
	input logic [clock_pkg::NUM_WEEKDAYS-1:0] led
);

	localparam int SECS_PER_DAY = 86400;

	int   cyc;      // clock edges since reset release
	logic err_seen;

	initial err_seen = 1'b0;

	always_ff @(posedge rst or posedge mclk) begin
		if (mclk)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// reference time model
	//////////////////////////////////////////////////////////////////////

	// seconds held by the counter after edge c, first tick at edge div_ratio
	function automatic int secs_at(input int c);
		if (c < 1)
			return 0;
		return (c - 1) / div_ratio;
	endfunction

	function automatic int hour_of(input int total);
		return (total % SECS_PER_DAY) / 3600;
	endfunction

	function automatic clock_pkg::bcd_digit_t digit_at(input int total, input int pos);
		int s;
		int h;
		int m;
		int sec;
		s   = total % SECS_PER_DAY;
		h   = s / 3600;
		m   = (s / 60) % 60;
		sec = s % 60;
		case (pos)
			0: return 4'(sec % 10);
			1: return 4'(sec / 10);
			2: return 4'(m % 10);
			3: return 4'(m / 10);
			4: return 4'(h % 10);
			default: return 4'(h / 10);
		endcase
	endfunction

	// common line per scan position, seconds units on bit 7
	function automatic logic [7:0] com_for_pos(input int pos);
		case (pos)
			0: return 8'b0111_1111;
			1: return 8'b1011_1111;
			2: return 8'b1110_1111;
			3: return 8'b1111_0111;
			4: return 8'b1111_1101;
			default: return 8'b1111_1110;
		endcase
	endfunction

	function automatic logic [clock_pkg::NUM_WEEKDAYS-1:0] led_for(input int total);
		int d;
		d = (total / SECS_PER_DAY) % clock_pkg::NUM_WEEKDAYS;
		return 7'b100_0000 >> d; // day 0 on the left
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	a_com_single_zero: assert property (@(posedge rst) disable iff (mclk)
		(cyc >= 1) |-> ($countones(seg_com) == 7))
	else begin
		$error("[FAIL] %0t seg_com expected one zero bit actual %b", $time, $sampled(seg_com));
		err_seen = 1'b1;
	end

	a_com_walk: assert property (@(posedge rst) disable iff (mclk)
		(cyc >= 1) |-> (seg_com == com_for_pos((cyc - 1) % clock_pkg::NUM_DIGITS)))
	else begin
		$error("[FAIL] %0t seg_com expected %b actual %b", $time,
			com_for_pos(($sampled(cyc) - 1) % clock_pkg::NUM_DIGITS), $sampled(seg_com));
		err_seen = 1'b1;
	end

	// digit as the model held it one cycle before
	a_seg_digit: assert property (@(posedge rst) disable iff (mclk)
		(cyc >= 1) |-> (seg_data == clock_pkg::seg_encode(
			digit_at(secs_at(cyc - 1), (cyc - 1) % clock_pkg::NUM_DIGITS))))
	else begin
		$error("[FAIL] %0t seg_data expected %h actual %h", $time,
			clock_pkg::seg_encode(digit_at(secs_at($sampled(cyc) - 1),
			($sampled(cyc) - 1) % clock_pkg::NUM_DIGITS)), $sampled(seg_data));
		err_seen = 1'b1;
	end

	a_am_flag: assert property (@(posedge rst) disable iff (mclk)
		(cyc >= 1) |-> (am == (hour_of(secs_at(cyc - 1)) >= 12)))
	else begin
		$error("[FAIL] %0t am expected %0d actual %0d", $time,
			hour_of(secs_at($sampled(cyc) - 1)) >= 12, $sampled(am));
		err_seen = 1'b1;
	end

	a_led_one_hot: assert property (@(posedge rst) disable iff (mclk)
		$onehot(led))
	else begin
		$error("[FAIL] %0t led expected one-hot actual %b", $time, $sampled(led));
		err_seen = 1'b1;
	end

	a_led_day: assert property (@(posedge rst) disable iff (mclk)
		(cyc >= 1) |-> (led == led_for(secs_at(cyc - 1))))
	else begin
		$error("[FAIL] %0t led expected %b actual %b", $time,
			led_for(secs_at($sampled(cyc) - 1)), $sampled(led));
		err_seen = 1'b1;
	end

endmodule

bind wall_clock_top wall_clock_asserts #(
	.div_ratio(div_ratio)
) wall_clock_asserts_i (
	.rst      (rst),
	.mclk     (mclk),
	.seg_data (seg_data),
	.seg_com  (seg_com),
	.am       (am),
	.led      (led)
);

/* dv/wall_clock_tb.sv */
`timescale 1ns/100ps

module wall_clock_tb;

	localparam int DIV_RATIO    = 2;  // two cycles per simulated second
	localparam int RUN_DAYS     = 8;  // one lap of the weekday leds and one more
	localparam int RESET_CYCLES = 4;
	localparam int SECS_PER_DAY = 86400;

	// 1,382,400 cycles of ticks plus margin, 1.5 million in all
	localparam int RUN_CYCLES     = RUN_DAYS * SECS_PER_DAY * DIV_RATIO;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + 117_600;

	logic                               rst;  // clock
	logic                               mclk; // reset, active high
	logic [7:0]                         seg_data;
	logic [7:0]                         seg_com;
	logic                               am;
	logic [clock_pkg::NUM_WEEKDAYS-1:0] led;
	int                                 cycle_cnt = 0;

	wall_clock_top #(
		.div_ratio(DIV_RATIO)
	) wall_clock_top_i (
		.rst      (rst),
		.mclk     (mclk),
		.seg_data (seg_data),
		.seg_com  (seg_com),
		.am       (am),
		.led      (led)
	);

	//////////////////////////////////////////////////////////////////////
	// clock, timeout and error watch
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst = 1'b0;
		forever #5 rst = ~rst; // 10 ns period
	end

	always @(posedge rst) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: eight days did not pass within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// bound checker raises its flag on any failed assertion
	always @(negedge rst) begin
		if (wall_clock_top_i.wall_clock_asserts_i.err_seen) begin
			$display("Finished with errors");
			$fatal(1, "assertion failure in the bound checker");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		mclk = 1'b1;
		repeat (RESET_CYCLES) @(posedge rst);
		@(negedge rst);
		mclk = 1'b0; // release away from the active edge
	endtask

	// each midnight moves the lit weekday led
	task automatic wait_for_day_changes(input int days);
		int                                 seen;
		logic [clock_pkg::NUM_WEEKDAYS-1:0] last_led;
		seen     = 0;
		last_led = led;
		while (seen < days) begin
			@(negedge rst);
			if (led != last_led) begin
				seen     = seen + 1;
				last_led = led;
			end
		end
	endtask

	initial begin
		apply_reset();
		wait_for_day_changes(RUN_DAYS);
		repeat (2) @(negedge rst); // last led and am checks
		if (wall_clock_top_i.wall_clock_asserts_i.err_seen) begin
			$display("Finished with errors");
			$fatal(1, "assertion failure in the bound checker");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the wall clock testbench with Verilator
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module wall_clock_tb \
	-f vlog.f -o wall_clock_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/wall_clock_sim > sim.log 2>&1

grep -qx "Finished with no errors" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL, see sim.log"; exit 1; }

/* verilog/calendar_tracker.sv */
`timescale 1ns/100ps

module calendar_tracker (
	input  logic                                rst,
	input  logic                                mclk,
	input  clock_pkg::clock_time_t              cur_time,
	input  logic                                day_carry,
	output logic                                am,
	output logic [clock_pkg::NUM_WEEKDAYS-1:0]  led
);

	localparam int DAY_W = $clog2(clock_pkg::NUM_WEEKDAYS);
	localparam logic [DAY_W-1:0] DAY_LAST = DAY_W'(clock_pkg::NUM_WEEKDAYS - 1);

	// index 0 sits on the leftmost led
	localparam logic [clock_pkg::NUM_WEEKDAYS-1:0] LED_FIRST =
		{1'b1, {(clock_pkg::NUM_WEEKDAYS-1){1'b0}}};

	logic [DAY_W-1:0] weekday;
	logic [DAY_W-1:0] next_weekday;
	logic             is_noon;
	logic             is_midnight_hour;

	assign is_noon = (cur_time.hour_tens == clock_pkg::NOON_TENS) &&
		(cur_time.hour_units == clock_pkg::NOON_UNITS);
	assign is_midnight_hour = (cur_time.hour_tens == '0) && (cur_time.hour_units == '0);

	always_comb begin
		next_weekday = weekday;
		if (day_carry) begin
			if (weekday == DAY_LAST)
				next_weekday = '0;
			else
				next_weekday = weekday + 1'b1;
		end
	end

	// led follows next_weekday so both change on the same edge
	always_ff @(posedge rst or posedge mclk) begin
		if (mclk) begin
			am      <= 1'b0;
			weekday <= '0;
			led     <= LED_FIRST;
		end else begin
			if (is_noon)
				am <= 1'b1; // flag set for 12..23
			else if (is_midnight_hour)
				am <= 1'b0;
			weekday <= next_weekday;
			led     <= LED_FIRST >> next_weekday;
		end
	end

endmodule

/* verilog/clock_pkg.sv */
package clock_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes and rates
	//////////////////////////////////////////////////////////////////////

	localparam int TICK_DIV     = 1000; // three decade stages
	localparam int NUM_DIGITS   = 6;
	localparam int NUM_WEEKDAYS = 7;

	//////////////////////////////////////////////////////////////////////
	// time types
	//////////////////////////////////////////////////////////////////////

	typedef logic [3:0] bcd_digit_t; // ones digit, 0..9
	typedef logic [2:0] bcd_tens_t;  // tens digit, 0..5 or 0..2

	// msb first, hours down to seconds
	typedef struct packed {
		bcd_tens_t  hour_tens;
		bcd_digit_t hour_units;
		bcd_tens_t  min_tens;
		bcd_digit_t min_units;
		bcd_tens_t  sec_tens;
		bcd_digit_t sec_units;
	} clock_time_t;

	// display positions in scan order
	typedef enum logic [$clog2(NUM_DIGITS)-1:0] {
		pos_sec_units,
		pos_sec_tens,
		pos_min_units,
		pos_min_tens,
		pos_hour_units,
		pos_hour_tens
	} scan_pos_t;

	//////////////////////////////////////////////////////////////////////
	// digit limits
	//////////////////////////////////////////////////////////////////////

	localparam bcd_digit_t UNITS_MAX    = 4'd9;
	localparam bcd_tens_t  SEC_TENS_MAX = 3'd5; // also minutes

	// hours go back to 00 at 24
	localparam bcd_tens_t  HOUR_WRAP_TENS  = 3'd2;
	localparam bcd_digit_t HOUR_WRAP_UNITS = 4'd4;

	// pm starts here
	localparam bcd_tens_t  NOON_TENS  = 3'd1;
	localparam bcd_digit_t NOON_UNITS = 4'd2;

	localparam logic [7:0] SEG_COM_OFF = 8'hff; // all commons idle

	// active high segments, bit 7 is the dot
	function automatic logic [7:0] seg_encode(input bcd_digit_t digit);
		logic [7:0] pattern;
		case (digit)
			4'h0: pattern = 8'b0011_1111;
			4'h1: pattern = 8'b0000_0110;
			4'h2: pattern = 8'b0101_1011;
			4'h3: pattern = 8'b0100_1111;
			4'h4: pattern = 8'b0110_0110;
			4'h5: pattern = 8'b0110_1101;
			4'h6: pattern = 8'b0111_1101;
			4'h7: pattern = 8'b0000_0111;
			4'h8: pattern = 8'b0111_1111;
			4'h9: pattern = 8'b0110_0111;
			default: pattern = 8'b0000_0000; // blank for non-bcd
		endcase
		return pattern;
	endfunction

endpackage

/* verilog/seg_scanner.sv */
`timescale 1ns/100ps

module seg_scanner (
	input  logic                   rst,
	input  logic                   mclk,
	input  clock_pkg::clock_time_t cur_time,
	output logic [7:0]             seg_data,
	output logic [7:0]             seg_com
);

	clock_pkg::scan_pos_t scan_pos;
	clock_pkg::scan_pos_t next_pos;
	clock_pkg::bcd_digit_t digit;
	logic [7:0]           com_pat;

	//////////////////////////////////////////////////////////////////////
	// digit select and common pattern per position
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_pos = clock_pkg::pos_sec_units;
		digit    = cur_time.sec_units;
		com_pat  = 8'b0111_1111;
		case (scan_pos)
			clock_pkg::pos_sec_units: begin
				next_pos = clock_pkg::pos_sec_tens;
				digit    = cur_time.sec_units;
				com_pat  = 8'b0111_1111; // rightmost digit first
			end
			clock_pkg::pos_sec_tens: begin
				next_pos = clock_pkg::pos_min_units;
				digit    = {1'b0, cur_time.sec_tens};
				com_pat  = 8'b1011_1111;
			end
			clock_pkg::pos_min_units: begin
				next_pos = clock_pkg::pos_min_tens;
				digit    = cur_time.min_units;
				com_pat  = 8'b1110_1111;
			end
			clock_pkg::pos_min_tens: begin
				next_pos = clock_pkg::pos_hour_units;
				digit    = {1'b0, cur_time.min_tens};
				com_pat  = 8'b1111_0111;
			end
			clock_pkg::pos_hour_units: begin
				next_pos = clock_pkg::pos_hour_tens;
				digit    = cur_time.hour_units;
				com_pat  = 8'b1111_1101;
			end
			clock_pkg::pos_hour_tens: begin
				next_pos = clock_pkg::pos_sec_units; // wrap around
				digit    = {1'b0, cur_time.hour_tens};
				com_pat  = 8'b1111_1110;
			end
			default: begin
				next_pos = clock_pkg::pos_sec_units;
			end
		endcase
	end

	always_ff @(posedge rst or posedge mclk) begin
		if (mclk) begin
			scan_pos <= clock_pkg::pos_sec_units;
			seg_data <= '0;
			seg_com  <= clock_pkg::SEG_COM_OFF;
		end else begin
			scan_pos <= next_pos;
			seg_data <= clock_pkg::seg_encode(digit);
			seg_com  <= com_pat;
		end
	end

endmodule

/* verilog/tick_divider.sv */
`timescale 1ns/100ps

module tick_divider #(
	parameter int div_ratio = clock_pkg::TICK_DIV
) (
	input  logic rst,
	input  logic mclk,
	output logic sec_tick
);

	// at least one bit, even for a ratio of 1
	localparam int CNT_W = (div_ratio > 1) ? $clog2(div_ratio) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(div_ratio - 1);

	logic [CNT_W-1:0] cnt;
	logic             cnt_wrap;

	assign cnt_wrap = (cnt == CNT_LAST);

	// free-running, one strobe per wrap
	always_ff @(posedge rst or posedge mclk) begin
		if (mclk) begin
			cnt      <= '0;
			sec_tick <= 1'b0;
		end else begin
			sec_tick <= cnt_wrap;
			if (cnt_wrap)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

/* verilog/time_counter.sv */
`timescale 1ns/100ps

module time_counter (
	input  logic                   rst,
	input  logic                   mclk,
	input  logic                   sec_tick,
	output clock_pkg::clock_time_t cur_time,
	output logic                   day_carry
);

	clock_pkg::clock_time_t next_time;

	logic sec_units_wrap;
	logic sec_tens_wrap;
	logic min_units_wrap;
	logic min_tens_wrap;
	logic hour_wrap;

	//////////////////////////////////////////////////////////////////////
	// carry chain, each stage needs all lower stages at their limit
	//////////////////////////////////////////////////////////////////////

	assign sec_units_wrap = (cur_time.sec_units == clock_pkg::UNITS_MAX);
	assign sec_tens_wrap  = sec_units_wrap &&
		(cur_time.sec_tens == clock_pkg::SEC_TENS_MAX);
	assign min_units_wrap = sec_tens_wrap &&
		(cur_time.min_units == clock_pkg::UNITS_MAX);
	assign min_tens_wrap  = min_units_wrap &&
		(cur_time.min_tens == clock_pkg::SEC_TENS_MAX);

	// 23:59:59, the next second is 24 which reads as 00
	assign hour_wrap = min_tens_wrap &&
		(cur_time.hour_tens == clock_pkg::HOUR_WRAP_TENS) &&
		(cur_time.hour_units == clock_pkg::HOUR_WRAP_UNITS - 4'd1);

	always_comb begin
		next_time = cur_time;

		if (sec_units_wrap)
			next_time.sec_units = '0;
		else
			next_time.sec_units = cur_time.sec_units + 4'd1;

		if (sec_units_wrap) begin
			if (sec_tens_wrap)
				next_time.sec_tens = '0;
			else
				next_time.sec_tens = cur_time.sec_tens + 3'd1;
		end

		if (sec_tens_wrap) begin
			if (min_units_wrap)
				next_time.min_units = '0;
			else
				next_time.min_units = cur_time.min_units + 4'd1;
		end

		if (min_units_wrap) begin
			if (min_tens_wrap)
				next_time.min_tens = '0;
			else
				next_time.min_tens = cur_time.min_tens + 3'd1;
		end

		// hours, 09 -> 10 and 19 -> 20 as well as the midnight wrap
		if (min_tens_wrap) begin
			if (hour_wrap) begin
				next_time.hour_tens  = '0;
				next_time.hour_units = '0;
			end else if (cur_time.hour_units == clock_pkg::UNITS_MAX) begin
				next_time.hour_tens  = cur_time.hour_tens + 3'd1;
				next_time.hour_units = '0;
			end else begin
				next_time.hour_units = cur_time.hour_units + 4'd1;
			end
		end
	end

	always_ff @(posedge rst or posedge mclk) begin
		if (mclk) begin
			cur_time  <= '0;
			day_carry <= 1'b0;
		end else begin
			day_carry <= sec_tick && hour_wrap; // same cycle as 00:00:00
			if (sec_tick)
				cur_time <= next_time;
		end
	end

endmodule

/* verilog/wall_clock_top.sv */
`timescale 1ns/100ps

module wall_clock_top #(
	parameter int div_ratio = clock_pkg::TICK_DIV
) (
	input  logic                               rst,
	input  logic                               mclk,
	output logic [7:0]                         seg_data,
	output logic [7:0]                         seg_com,
	output logic                               am,
	output logic [clock_pkg::NUM_WEEKDAYS-1:0] led
);

	logic                   sec_tick;
	logic                   day_carry;
	clock_pkg::clock_time_t cur_time;

	//////////////////////////////////////////////////////////////////////
	// stage 1, seconds strobe
	//////////////////////////////////////////////////////////////////////

	tick_divider #(
		.div_ratio(div_ratio)
	) tick_divider_i (
		.rst      (rst),
		.mclk     (mclk),
		.sec_tick (sec_tick)
	);

	//////////////////////////////////////////////////////////////////////
	// stage 2, bcd time of day
	//////////////////////////////////////////////////////////////////////

	time_counter time_counter_i (
		.rst       (rst),
		.mclk      (mclk),
		.sec_tick  (sec_tick),
		.cur_time  (cur_time),
		.day_carry (day_carry)
	);

	//////////////////////////////////////////////////////////////////////
	// stage 3, calendar and display side by side
	//////////////////////////////////////////////////////////////////////

	calendar_tracker calendar_tracker_i (
		.rst       (rst),
		.mclk      (mclk),
		.cur_time  (cur_time),
		.day_carry (day_carry),
		.am        (am),
		.led       (led)
	);

	// six digits, one per cycle
	seg_scanner seg_scanner_i (
		.rst      (rst),
		.mclk     (mclk),
		.cur_time (cur_time),
		.seg_data (seg_data),
		.seg_com  (seg_com)
	);

endmodule

/* vlog.f */
verilog/clock_pkg.sv
verilog/tick_divider.sv
verilog/time_counter.sv
verilog/calendar_tracker.sv
verilog/seg_scanner.sv
verilog/wall_clock_top.sv
dv/wall_clock_asserts.sv
dv/wall_clock_tb.sv
